//--- Bender.yml
package:
  name: tlu_controller

sources:
  - include_dirs:
      - src
    files:
      - src/tlu_pkg.sv
      - src/tlu_trigger_sync.sv
      - src/tlu_controller_fsm.sv
      - src/tlu_serial_to_parallel.sv
      - src/tlu_controller.sv
  - target: test
    include_dirs:
      - src
    files:
      - verification/tlu_controller_tb.sv

//--- src/tlu_controller.sv
// single CLK domain except tlu_trigger; readout FIFO and command sequencer are outside this block
`default_nettype none
`timescale 1ns/10ps

`include "tlu_defs.svh"

module tlu_controller
    import tlu_pkg::*;
(
    input  wire logic       CLK,
    input  wire logic       RESET,
    input  wire logic       tlu_trigger,
    input  wire tlu_mode_t  tlu_mode,
    input  wire logic [7:0] trigger_low_timeout,
    input  wire logic       cmd_ready,
    input  wire logic       cmd_ext_start_enable,
    input  wire logic       fifo_near_full,
    output logic            tlu_busy,
    output logic            tlu_clock,
    output logic            tlu_assert_veto,
    output logic            tlu_deassert_veto,
    output logic            cmd_ext_start_flag,
    output logic            trigger_accepted,
    output logic            trigger_low_timeout_error,
    output logic            trigger_accept_error,
    output tlu_trigger_word_t trigger_word,
    output logic            trigger_word_strobe
);

    logic                            trigger_sync;
    logic                            trigger_flag;
    logic [`TLU_TIMESTAMP_BITS-1:0] timestamp;
    logic                            receive_data_flag;
    logic                            data_received_flag;

    tlu_trigger_sync u_trigger_sync (
        .CLK          (CLK),
        .RESET        (RESET),
        .tlu_trigger  (tlu_trigger),
        .trigger_sync (trigger_sync),
        .trigger_flag (trigger_flag),
        .timestamp    (timestamp)
    );

    tlu_controller_fsm u_controller_fsm (
        .CLK                       (CLK),
        .RESET                     (RESET),
        .cmd_ready                 (cmd_ready),
        .cmd_ext_start_enable      (cmd_ext_start_enable),
        .trigger_sync              (trigger_sync),
        .trigger_flag              (trigger_flag),
        .tlu_mode                  (tlu_mode),
        .trigger_low_timeout       (trigger_low_timeout),
        .data_received_flag        (data_received_flag),
        .fifo_near_full            (fifo_near_full),
        .cmd_ext_start_flag        (cmd_ext_start_flag),
        .tlu_busy                  (tlu_busy),
        .tlu_assert_veto           (tlu_assert_veto),
        .tlu_deassert_veto         (tlu_deassert_veto),
        .receive_data_flag         (receive_data_flag),
        .trigger_low_timeout_error (trigger_low_timeout_error),
        .trigger_accept_error      (trigger_accept_error),
        .trigger_accepted          (trigger_accepted)
    );

    // serial data comes back on the trigger line
    tlu_serial_to_parallel u_serial_to_parallel (
        .CLK                 (CLK),
        .RESET               (RESET),
        .tlu_mode            (tlu_mode),
        .receive_data_flag   (receive_data_flag),
        .trigger_accepted    (trigger_accepted),
        .trigger_sync        (trigger_sync),
        .timestamp           (timestamp),
        .tlu_clock           (tlu_clock),
        .data_received_flag  (data_received_flag),
        .trigger_word        (trigger_word),
        .trigger_word_strobe (trigger_word_strobe)
    );

endmodule

`default_nettype wire

//--- src/tlu_controller_fsm.sv
// outputs are registered from the next state; accept error stays set until RESET
`default_nettype none
`timescale 1ns/10ps

module tlu_controller_fsm
    import tlu_pkg::*;
(
    input  wire logic      CLK,
    input  wire logic      RESET,
    input  wire logic      cmd_ready,
    input  wire logic      cmd_ext_start_enable,
    input  wire logic      trigger_sync,
    input  wire logic      trigger_flag,
    input  wire tlu_mode_t tlu_mode,
    input  wire logic [7:0] trigger_low_timeout,
    input  wire logic      data_received_flag,
    input  wire logic      fifo_near_full,
    output logic           cmd_ext_start_flag,
    output logic           tlu_busy,
    output logic           tlu_assert_veto,
    output logic           tlu_deassert_veto,
    output logic           receive_data_flag,
    output logic           trigger_low_timeout_error,
    output logic           trigger_accept_error,
    output logic           trigger_accepted
);

    tlu_fsm_state_t state;
    tlu_fsm_state_t next_state;
    logic [7:0]     low_time_count;
    logic           data_received_seen;
    logic           data_mode;
    logic           accept;

    assign data_mode = (tlu_mode == DATA_HANDSHAKE) || (tlu_mode == DATA_HANDSHAKE_NUMBER);
    // level fallback in data modes, in case the TLU hangs with trigger high
    assign accept = cmd_ready && cmd_ext_start_enable
                    && (trigger_flag || (trigger_sync && data_mode));

    always_ff @(posedge CLK or posedge RESET)
    begin
        if (RESET)
            state <= IDLE;
        else
            state <= next_state;
    end

    always_comb
    begin
        next_state = state;
        case (state)
            IDLE:
                if (accept)
                    next_state = SEND_COMMAND;
            SEND_COMMAND:
                if (data_mode)
                    next_state = WAIT_FOR_TRIGGER_LOW;
                else
                    next_state = WAIT_FOR_CMD;
            WAIT_FOR_TRIGGER_LOW:
                if (trigger_low_timeout_error)
                    next_state = RECEIVE_TRIGGER_DATA;
                else if (!trigger_sync && tlu_mode == DATA_HANDSHAKE)
                    next_state = WAIT_FOR_TLU_DATA;
                else if (!trigger_sync)
                    next_state = RECEIVE_TRIGGER_DATA;
            RECEIVE_TRIGGER_DATA:
                next_state = WAIT_FOR_TLU_DATA;
            WAIT_FOR_TLU_DATA:
                // mode 10 word may already be written before we get here
                if (data_received_flag || data_received_seen)
                    next_state = WAIT_FOR_CMD;
            WAIT_FOR_CMD:
                if (cmd_ready)
                    next_state = IDLE;
            default:
                next_state = IDLE;
        endcase
    end

    always_ff @(posedge CLK or posedge RESET)
    begin
        if (RESET)
        begin
            cmd_ext_start_flag        <= 1'b0;
            tlu_busy                  <= 1'b0;
            tlu_assert_veto           <= 1'b0;
            tlu_deassert_veto         <= 1'b0;
            receive_data_flag         <= 1'b0;
            trigger_low_timeout_error <= 1'b0;
            trigger_accept_error      <= 1'b0;
            trigger_accepted          <= 1'b0;
            low_time_count            <= 8'd0;
            data_received_seen        <= 1'b0;
        end
        else
        begin
            // busy states share these values
            cmd_ext_start_flag <= 1'b0;
            tlu_busy           <= 1'b1;
            tlu_assert_veto    <= 1'b0;
            tlu_deassert_veto  <= 1'b0;
            receive_data_flag  <= 1'b0;
            trigger_accepted   <= 1'b1;
            low_time_count     <= 8'd0;
            if (data_received_flag)
                data_received_seen <= 1'b1;

            case (next_state)
                IDLE:
                begin
                    tlu_busy                  <= 1'b0;
                    trigger_accepted          <= 1'b0;
                    trigger_low_timeout_error <= 1'b0;
                    data_received_seen        <= 1'b0;
                    if (!cmd_ext_start_enable || fifo_near_full)
                        tlu_assert_veto <= 1'b1;
                    else
                        tlu_deassert_veto <= 1'b1;
                    // level high without an edge, trigger was missed
                    if (trigger_sync && !trigger_flag)
                        trigger_accept_error <= 1'b1;
                end
                SEND_COMMAND:
                begin
                    cmd_ext_start_flag        <= 1'b1;
                    trigger_low_timeout_error <= 1'b0;
                end
                WAIT_FOR_TRIGGER_LOW:
                begin
                    tlu_deassert_veto <= 1'b1;
                    // saturates at 255
                    if (low_time_count != 8'hff)
                        low_time_count <= low_time_count + 8'd1;
                    else
                        low_time_count <= low_time_count;
                    trigger_low_timeout_error <= (trigger_low_timeout != 8'd0)
                        && (low_time_count >= trigger_low_timeout);
                end
                RECEIVE_TRIGGER_DATA:
                    receive_data_flag <= 1'b1;
                default:
                begin
                end
            endcase
        end
    end

    // one command start per accepted trigger
    assert property (@(posedge CLK) disable iff (RESET)
        cmd_ext_start_flag |=> !cmd_ext_start_flag);

    // busy only drops once the command side is ready again
    assert property (@(posedge CLK) disable iff (RESET)
        $fell(tlu_busy) |-> $past(cmd_ready));

endmodule

`default_nettype wire

//--- src/tlu_defs.svh
// compile-time sizes; trigger number width must stay between 1 and 31, timestamp width must be 31
`ifndef TLU_DEFS_SVH
`define TLU_DEFS_SVH

// width of the serial trigger number sent by the TLU
// the trigger word has 31 bits of payload, so 31 is the upper limit
`define TLU_TRIGGER_BITS 15

// width of the free-running timestamp counter
// fills the trigger word below the marker bit
`define TLU_TIMESTAMP_BITS 31

// CLK cycles spent in each phase of the TLU serial clock
// one full serial clock period is twice this value
`define TLU_CLOCK_HALF_PERIOD 1

`endif

//--- src/tlu_pkg.sv
// shared types; the trigger word layout assumes TLU_TIMESTAMP_BITS is 31
`default_nettype none

package tlu_pkg;

`include "tlu_defs.svh"

    // handshake mode selected by the readout
    typedef enum logic [1:0] {
        NO_HANDSHAKE          = 2'b00,
        SIMPLE_HANDSHAKE      = 2'b01,
        DATA_HANDSHAKE        = 2'b10,
        DATA_HANDSHAKE_NUMBER = 2'b11
    } tlu_mode_t;

    // acceptance FSM states
    typedef enum logic [2:0] {
        IDLE                 = 3'd0,
        SEND_COMMAND         = 3'd1,
        WAIT_FOR_TRIGGER_LOW = 3'd2,
        RECEIVE_TRIGGER_DATA = 3'd3,
        WAIT_FOR_TLU_DATA    = 3'd4,
        WAIT_FOR_CMD         = 3'd5
    } tlu_fsm_state_t;

    // word written in mode 11, number zero-extended
    typedef struct packed {
        logic        marker;
        logic [30:0] trigger_number;
    } tlu_number_word_t;

    // word written in modes 00 to 10
    typedef struct packed {
        logic                            marker;
        logic [`TLU_TIMESTAMP_BITS-1:0] timestamp;
    } tlu_timestamp_word_t;

    // the mode at write time tells which view is valid
    typedef union packed {
        tlu_number_word_t    number_view;
        tlu_timestamp_word_t timestamp_view;
    } tlu_trigger_word_t;

endpackage

`default_nettype wire

//--- src/tlu_serial_to_parallel.sv
// sampling is delayed by 3 CLK cycles to match the synchronizer depth; number transfer in mode 11 only
`default_nettype none
`timescale 1ns/10ps

`include "tlu_defs.svh"

module tlu_serial_to_parallel
    import tlu_pkg::*;
(
    input  wire logic                            CLK,
    input  wire logic                            RESET,
    input  wire tlu_mode_t                       tlu_mode,
    input  wire logic                            receive_data_flag,
    input  wire logic                            trigger_accepted,
    input  wire logic                            trigger_sync,
    input  wire logic [`TLU_TIMESTAMP_BITS-1:0]  timestamp,
    output logic                                 tlu_clock,
    output logic                                 data_received_flag,
    output tlu_trigger_word_t                    trigger_word,
    output logic                                 trigger_word_strobe
);

    localparam int BITS   = `TLU_TRIGGER_BITS;
    localparam int HALF   = `TLU_CLOCK_HALF_PERIOD;
    localparam int HALF_W = (HALF > 1) ? $clog2(HALF) : 1;
    localparam int BIT_W  = (BITS > 1) ? $clog2(BITS) : 1;

    logic              active;
    logic              start;
    logic              last_low;
    logic              final_low;
    logic [HALF_W-1:0] half_cnt;
    logic [BIT_W-1:0]  bit_cnt;
    logic [2:0]        sample_pipe;
    logic [2:0]        final_pipe;
    logic [BITS-1:0]   shift_reg;
    logic [BITS:0]     shift_ext;
    logic              accepted_d;
    logic              word_start;
    logic              number_done;

    assign start       = receive_data_flag && (tlu_mode == DATA_HANDSHAKE_NUMBER) && !active;
    // last cycle of a low phase of the serial clock
    assign last_low    = active && !tlu_clock && (half_cnt == HALF_W'(HALF - 1));
    assign final_low   = last_low && (bit_cnt == BIT_W'(BITS - 1));
    // LSB first, so new bits enter at the top
    assign shift_ext   = {trigger_sync, shift_reg};
    assign word_start  = trigger_accepted && !accepted_d && (tlu_mode != DATA_HANDSHAKE_NUMBER);
    assign number_done = final_pipe[2];

    // serial clock, high phase first
    always_ff @(posedge CLK or posedge RESET)
    begin
        if (RESET)
        begin
            active    <= 1'b0;
            tlu_clock <= 1'b0;
            half_cnt  <= '0;
            bit_cnt   <= '0;
        end
        else if (start)
        begin
            active    <= 1'b1;
            tlu_clock <= 1'b1;
            half_cnt  <= '0;
            bit_cnt   <= '0;
        end
        else if (active)
        begin
            if (half_cnt != HALF_W'(HALF - 1))
                half_cnt <= half_cnt + 1'b1;
            else
            begin
                half_cnt <= '0;
                if (tlu_clock)
                    tlu_clock <= 1'b0;
                else if (bit_cnt == BIT_W'(BITS - 1))
                    active <= 1'b0;
                else
                begin
                    bit_cnt   <= bit_cnt + 1'b1;
                    tlu_clock <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge CLK or posedge RESET)
    begin
        if (RESET)
        begin
            sample_pipe         <= 3'b000;
            final_pipe          <= 3'b000;
            accepted_d          <= 1'b0;
            data_received_flag  <= 1'b0;
            trigger_word_strobe <= 1'b0;
        end
        else
        begin
            sample_pipe         <= {sample_pipe[1:0], last_low};
            final_pipe          <= {final_pipe[1:0], final_low};
            accepted_d          <= trigger_accepted;
            data_received_flag  <= number_done || word_start;
            trigger_word_strobe <= number_done || word_start;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (sample_pipe[2])
            shift_reg <= shift_ext[BITS:1];
        if (number_done)
        begin
            trigger_word.number_view.marker         <= 1'b1;
            trigger_word.number_view.trigger_number <= 31'(shift_ext[BITS:1]);
        end
        else if (word_start)
        begin
            trigger_word.timestamp_view.marker    <= 1'b1;
            trigger_word.timestamp_view.timestamp <= timestamp;
        end
    end

    // serial clock idles low between transfers
    assert property (@(posedge CLK) disable iff (RESET)
        !active |-> !tlu_clock);

endmodule

`default_nettype wire

//--- src/tlu_trigger_sync.sv
// tlu_trigger is asynchronous; flag and synchronized level both appear 3 CLK cycles after the edge
`default_nettype none
`timescale 1ns/10ps

`include "tlu_defs.svh"

module tlu_trigger_sync (
    input  wire logic                            CLK,
    input  wire logic                            RESET,
    input  wire logic                            tlu_trigger,
    output logic                                 trigger_sync,
    output logic                                 trigger_flag,
    output logic [`TLU_TIMESTAMP_BITS-1:0]       timestamp
);

    logic                            trigger_meta;
    logic                            trigger_stage;
    logic                            rising_edge;
    logic [`TLU_TIMESTAMP_BITS-1:0] timestamp_counter;

    // trigger_sync is the edge-detect stage, so it rises together with the flag
    assign rising_edge = trigger_stage && !trigger_sync;

    always_ff @(posedge CLK or posedge RESET)
    begin
        if (RESET)
        begin
            trigger_meta      <= 1'b0;
            trigger_stage     <= 1'b0;
            trigger_sync      <= 1'b0;
            trigger_flag      <= 1'b0;
            timestamp_counter <= '0;
        end
        else
        begin
            trigger_meta      <= tlu_trigger;
            trigger_stage     <= trigger_meta;
            trigger_sync      <= trigger_stage;
            trigger_flag      <= rising_edge;
            timestamp_counter <= timestamp_counter + 1'b1;
        end
    end

    // captured on the same edge that raises the flag
    always_ff @(posedge CLK)
    begin
        if (rising_edge)
            timestamp <= timestamp_counter;
    end

endmodule

`default_nettype wire

//--- verification/tlu_controller_tb.sv
// the TLU model answers only on rising tlu_clock edges; wait limits scale with the serial transfer
`default_nettype none
`timescale 1ns/10ps

`include "tlu_defs.svh"

module tlu_controller_tb
    import tlu_pkg::*;
;

    localparam int WAIT_LIMIT  = 100 + 4 * `TLU_TRIGGER_BITS * `TLU_CLOCK_HALF_PERIOD;
    localparam int SEL_BUSY    = 0;
    localparam int SEL_STROBE  = 1;
    localparam int SEL_LOW_ERR = 2;

    logic              CLK;
    logic              RESET;
    logic              tlu_trigger;
    tlu_mode_t         tlu_mode;
    logic [7:0]        trigger_low_timeout;
    logic              cmd_ready;
    logic              cmd_ext_start_enable;
    logic              fifo_near_full;
    logic              tlu_busy;
    logic              tlu_clock;
    logic              tlu_assert_veto;
    logic              tlu_deassert_veto;
    logic              cmd_ext_start_flag;
    logic              trigger_accepted;
    logic              trigger_low_timeout_error;
    logic              trigger_accept_error;
    tlu_trigger_word_t trigger_word;
    logic              trigger_word_strobe;

    int                error_count;
    int                timeout_count;
    int                start_count;
    int                strobe_count;
    int                clock_edges;
    int                model_bit;
    logic [31:0]       rng_state;
    logic [`TLU_TRIGGER_BITS-1:0] tlu_number;

    tlu_controller DUT (
        .CLK                       (CLK),
        .RESET                     (RESET),
        .tlu_trigger               (tlu_trigger),
        .tlu_mode                  (tlu_mode),
        .trigger_low_timeout       (trigger_low_timeout),
        .cmd_ready                 (cmd_ready),
        .cmd_ext_start_enable      (cmd_ext_start_enable),
        .fifo_near_full            (fifo_near_full),
        .tlu_busy                  (tlu_busy),
        .tlu_clock                 (tlu_clock),
        .tlu_assert_veto           (tlu_assert_veto),
        .tlu_deassert_veto         (tlu_deassert_veto),
        .cmd_ext_start_flag        (cmd_ext_start_flag),
        .trigger_accepted          (trigger_accepted),
        .trigger_low_timeout_error (trigger_low_timeout_error),
        .trigger_accept_error      (trigger_accept_error),
        .trigger_word              (trigger_word),
        .trigger_word_strobe       (trigger_word_strobe)
    );

    always #5 CLK = ~CLK;

    // pulse counters, sampled on the clock
    always @(posedge CLK)
    begin
        if (!RESET && cmd_ext_start_flag)
            start_count++;
        if (!RESET && trigger_word_strobe)
            strobe_count++;
    end

    always @(negedge CLK)
    begin
        if (!RESET)
            check_bit("veto_exclusive", 1'b0, tlu_assert_veto && tlu_deassert_veto);
    end

    // TLU model, number goes out LSB first
    always @(posedge tlu_clock)
    begin
        clock_edges++;
        #1;
        if (model_bit < `TLU_TRIGGER_BITS)
        begin
            tlu_trigger = tlu_number[model_bit];
            model_bit++;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] value);
        logic [31:0] x;
        x = value;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected)
        begin
            $display("CHECK FAILED %s expected %0b actual %0b", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_word(input string name, input tlu_trigger_word_t expected,
                              input tlu_trigger_word_t actual);
        if (actual !== expected)
        begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_count(input string name, input int expected, input int actual);
        if (actual != expected)
        begin
            $display("CHECK FAILED %s expected %0d actual %0d", name, expected, actual);
            error_count++;
        end
    endtask

    // leaves the time 1 ns after a rising edge
    task automatic step(input int n);
        repeat (n) @(posedge CLK);
        #1;
    endtask

    task automatic wait_for(input int which, input logic level, input string what);
        int   cycles;
        logic value;
        cycles = 0;
        value  = ~level;
        while (value !== level && cycles < WAIT_LIMIT)
        begin
            step(1);
            case (which)
                SEL_BUSY:    value = tlu_busy;
                SEL_STROBE:  value = trigger_word_strobe;
                default:     value = trigger_low_timeout_error;
            endcase
            cycles++;
        end
        if (value !== level)
        begin
            $display("timeout: %s never went to %0b", what, level);
            timeout_count++;
        end
    endtask

    task automatic clear_counts();
        start_count  = 0;
        strobe_count = 0;
        clock_edges  = 0;
    endtask

    task automatic pulse_trigger();
        tlu_trigger = 1'b1;
        step(2);
        tlu_trigger = 1'b0;
    endtask

    task automatic no_handshake_trigger();
        tlu_trigger_word_t first_word;
        tlu_trigger_word_t second_word;
        tlu_mode = NO_HANDSHAKE;
        clear_counts();
        pulse_trigger();
        wait_for(SEL_STROBE, 1'b1, "mode 00 first word strobe");
        first_word = trigger_word;
        check_bit("mode00_marker", 1'b1, first_word.timestamp_view.marker);
        check_bit("mode00_accepted", 1'b1, trigger_accepted);
        wait_for(SEL_BUSY, 1'b0, "mode 00 busy release");
        check_bit("mode00_accepted_clear", 1'b0, trigger_accepted);
        step(3);
        check_count("mode00_start_flags", 1, start_count);
        check_count("mode00_words", 1, strobe_count);
        pulse_trigger();
        wait_for(SEL_STROBE, 1'b1, "mode 00 second word strobe");
        second_word = trigger_word;
        wait_for(SEL_BUSY, 1'b0, "mode 00 second busy release");
        step(3);
        check_bit("mode00_timestamp_order", 1'b1,
                  second_word.timestamp_view.timestamp > first_word.timestamp_view.timestamp);
        check_count("mode00_start_flags_total", 2, start_count);
        check_count("mode00_words_total", 2, strobe_count);
    endtask

    task automatic number_handshake();
        tlu_trigger_word_t expected;
        rng_state  = xorshift32(rng_state);
        tlu_number = rng_state[`TLU_TRIGGER_BITS-1:0];
        expected.number_view.marker         = 1'b1;
        expected.number_view.trigger_number = 31'(tlu_number);
        tlu_mode  = DATA_HANDSHAKE_NUMBER;
        model_bit = 0;
        clear_counts();
        tlu_trigger = 1'b1;
        wait_for(SEL_BUSY, 1'b1, "mode 11 busy");
        // hold the command side so busy must wait for it
        cmd_ready   = 1'b0;
        tlu_trigger = 1'b0;
        wait_for(SEL_STROBE, 1'b1, "mode 11 number word strobe");
        check_word("mode11_number", expected, trigger_word);
        check_count("mode11_clock_edges", `TLU_TRIGGER_BITS, clock_edges);
        check_bit("mode11_busy_held", 1'b1, tlu_busy);
        tlu_trigger = 1'b0;
        step(5);
        cmd_ready = 1'b1;
        wait_for(SEL_BUSY, 1'b0, "mode 11 busy release");
        check_count("mode11_words", 1, strobe_count);
    endtask

    task automatic low_time_timeout();
        tlu_mode            = DATA_HANDSHAKE;
        trigger_low_timeout = 8'd5;
        clear_counts();
        tlu_trigger = 1'b1;
        wait_for(SEL_LOW_ERR, 1'b1, "low-time timeout error");
        tlu_trigger = 1'b0;
        check_count("timeout_word_before_error", 1, strobe_count);
        check_bit("timeout_marker", 1'b1, trigger_word.timestamp_view.marker);
        wait_for(SEL_BUSY, 1'b0, "timeout busy release");
        step(3);
        check_count("timeout_start_flags", 1, start_count);
        check_count("timeout_words", 1, strobe_count);
        trigger_low_timeout = 8'd0;
    endtask

    task automatic veto_levels();
        tlu_mode = NO_HANDSHAKE;
        step(2);
        check_bit("veto_idle_assert", 1'b0, tlu_assert_veto);
        check_bit("veto_idle_deassert", 1'b1, tlu_deassert_veto);
        cmd_ext_start_enable = 1'b0;
        step(2);
        check_bit("veto_disabled_assert", 1'b1, tlu_assert_veto);
        check_bit("veto_disabled_deassert", 1'b0, tlu_deassert_veto);
        cmd_ext_start_enable = 1'b1;
        fifo_near_full       = 1'b1;
        step(2);
        check_bit("veto_full_assert", 1'b1, tlu_assert_veto);
        check_bit("veto_full_deassert", 1'b0, tlu_deassert_veto);
        fifo_near_full = 1'b0;
        step(2);
        check_bit("veto_clear_assert", 1'b0, tlu_assert_veto);
        check_bit("veto_clear_deassert", 1'b1, tlu_deassert_veto);
    endtask

    task automatic back_pressure();
        tlu_mode = SIMPLE_HANDSHAKE;
        clear_counts();
        pulse_trigger();
        wait_for(SEL_BUSY, 1'b1, "back-pressure busy");
        cmd_ready = 1'b0;
        pulse_trigger();
        // observation window for a stray second start
        step(10);
        check_bit("backpressure_busy_held", 1'b1, tlu_busy);
        check_count("backpressure_start_flags", 1, start_count);
        check_count("backpressure_words", 1, strobe_count);
        cmd_ready = 1'b1;
        wait_for(SEL_BUSY, 1'b0, "back-pressure busy release");
    endtask

    task automatic missed_trigger_error();
        tlu_mode = NO_HANDSHAKE;
        clear_counts();
        check_bit("accept_error_clear", 1'b0, trigger_accept_error);
        // edge comes while the command side is disabled, level stays high in IDLE
        cmd_ext_start_enable = 1'b0;
        pulse_trigger();
        step(5);
        check_bit("accept_error_set", 1'b1, trigger_accept_error);
        check_bit("accept_error_idle", 1'b0, tlu_busy);
        check_count("accept_error_start_flags", 0, start_count);
        check_count("accept_error_words", 0, strobe_count);
        cmd_ext_start_enable = 1'b1;
    endtask

    initial
    begin
        CLK                  = 1'b0;
        RESET                = 1'b1;
        tlu_trigger          = 1'b0;
        tlu_mode             = NO_HANDSHAKE;
        trigger_low_timeout  = 8'd0;
        cmd_ready            = 1'b1;
        cmd_ext_start_enable = 1'b1;
        fifo_near_full       = 1'b0;
        error_count          = 0;
        timeout_count        = 0;
        model_bit            = `TLU_TRIGGER_BITS;
        tlu_number           = '0;
        rng_state            = 32'h6210_d232;
        clear_counts();
        step(2);
        RESET = 1'b0;
        step(2);
        no_handshake_trigger();
        number_handshake();
        low_time_timeout();
        veto_levels();
        back_pressure();
        missed_trigger_error();
        $display("check errors: %0d, timeouts: %0d", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+src
src/tlu_pkg.sv
src/tlu_trigger_sync.sv
src/tlu_controller_fsm.sv
src/tlu_serial_to_parallel.sv
src/tlu_controller.sv
verification/tlu_controller_tb.sv
